//--- hdl/dcache_pkg.sv
/*
 * shared geometry and types for the 4-way 8 KB write-back data cache
 * address split: tag [31:11], index [10:4], byte offset [3:0]
 * every cache module imports this package
 */
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W     = 32;
    localparam int TAG_W      = 21;   // addr bits 31..11
    localparam int INDEX_W    = 7;    // addr bits 10..4
    localparam int OFFSET_W   = 4;    // byte within line
    localparam int WAYS       = 4;
    localparam int WAY_W      = 2;
    localparam int SETS       = 128;
    localparam int BEAT_W     = 64;   // one bus beat
    localparam int LINE_BYTES = 16;

    // cpu access size, natural alignment assumed
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,   // 1 byte
        SIZE_H = 2'd1,   // 2 bytes
        SIZE_W = 2'd2,   // 4 bytes
        SIZE_D = 2'd3    // 8 bytes
    } size_e;

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        LOOKUP  = 3'd1,   // tag compare, data read done
        EVICT   = 3'd2,   // dirty victim going out
        REFILL  = 3'd3,   // line coming in
        MERGE   = 3'd4,   // store miss, merge into refilled line
        RESPOND = 3'd5    // ready pulse to cpu
    } ctrl_state_e;

    // bus side sees two beats, merge side sees sixteen bytes
    typedef union packed {
        logic [1:0][BEAT_W-1:0]     beat;    // beat 0 = low 8 bytes
        logic [LINE_BYTES-1:0][7:0] bytes;
    } line_u;

endpackage

`default_nettype wire

//--- hdl/dcache_lane_align.sv
/*
 * byte lane steering between the cpu word and a cache line
 * store side: byte strobe from size and offset, data copied into both beats
 * load side: picks the beat, shifts down and zero-extends to 64 bits
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_lane_align (
    input  logic [dcache_pkg::OFFSET_W-1:0]   offset_i,
    input  dcache_pkg::size_e                 size_i,
    input  logic [dcache_pkg::BEAT_W-1:0]     wdata_i,
    input  dcache_pkg::line_u                 line_i,
    output dcache_pkg::line_u                 store_line_o,
    output logic [dcache_pkg::LINE_BYTES-1:0] store_strb_o,
    output logic [dcache_pkg::BEAT_W-1:0]     rdata_o
);
    import dcache_pkg::*;

    logic [LINE_BYTES-1:0] size_mask;
    logic [BEAT_W-1:0]     wshift, rshift;
    logic [5:0]            bit_off;   // offset within the beat, in bits

    assign bit_off = {offset_i[2:0], 3'b000};

    always_comb begin
        case (size_i)
            SIZE_B:  size_mask = 16'h0001;
            SIZE_H:  size_mask = 16'h0003;
            SIZE_W:  size_mask = 16'h000f;
            default: size_mask = 16'h00ff;   // double
        endcase
    end

    assign store_strb_o = size_mask << offset_i;   // aligned, never crosses a beat

    // same data in both beats, the strobe picks the half
    assign wshift            = wdata_i << bit_off;
    assign store_line_o.beat = {wshift, wshift};

    assign rshift = line_i.beat[offset_i[3]] >> bit_off;

    always_comb begin
        case (size_i)
            SIZE_B:  rdata_o = {56'd0, rshift[7:0]};
            SIZE_H:  rdata_o = {48'd0, rshift[15:0]};
            SIZE_W:  rdata_o = {32'd0, rshift[31:0]};
            default: rdata_o = rshift;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/dcache_refill.sv
/*
 * read channel engine
 * start_i raises mem_r_valid_o for one line-aligned burst of two beats
 * beats are assembled into line_o, done_o pulses after the last beat
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_refill (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start_i,
    input  logic [dcache_pkg::ADDR_W-1:0] line_addr_i,
    output logic                          mem_r_valid_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_r_addr_o,
    input  logic                          mem_r_ready_i,
    input  logic                          mem_r_last_i,
    input  logic [dcache_pkg::BEAT_W-1:0] mem_r_data_i,
    output dcache_pkg::line_u             line_o,
    output logic                          done_o
);
    import dcache_pkg::*;

    logic take;   // beat accepted this cycle

    assign take = mem_r_valid_o && mem_r_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_r_valid_o <= 1'b0;
            done_o        <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                mem_r_valid_o <= 1'b1;
            end else if (take && mem_r_last_i) begin
                mem_r_valid_o <= 1'b0;   // drops the cycle after the last beat
                done_o        <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) mem_r_addr_o <= line_addr_i;
        if (take) begin
            if (mem_r_last_i) line_o.beat[1] <= mem_r_data_i;
            else              line_o.beat[0] <= mem_r_data_i;
        end
    end

    a_last_in_burst: assert property (@(posedge clk) disable iff (rst)
        mem_r_last_i |-> mem_r_valid_o)
        else $error("read last outside a burst");

endmodule

`default_nettype wire

//--- hdl/dcache_writeback.sv
/*
 * write channel engine for dirty victims
 * start_i captures the victim line and address, then beat 0 and beat 1
 * go out in order, slave marks the second transfer with last
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_writeback (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start_i,
    input  logic [dcache_pkg::ADDR_W-1:0] line_addr_i,
    input  dcache_pkg::line_u             line_i,
    output logic                          mem_w_valid_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_w_addr_o,
    output logic [dcache_pkg::BEAT_W-1:0] mem_w_data_o,
    input  logic                          mem_w_ready_i,
    input  logic                          mem_w_last_i,
    output logic                          done_o
);
    import dcache_pkg::*;

    line_u line_q;   // copy, array may be rewritten by the refill
    logic  beat_q;   // beat on the bus
    logic  take;

    assign take         = mem_w_valid_o && mem_w_ready_i;
    assign mem_w_data_o = line_q.beat[beat_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_w_valid_o <= 1'b0;
            beat_q        <= 1'b0;
            done_o        <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                mem_w_valid_o <= 1'b1;
                beat_q        <= 1'b0;
            end else if (take) begin
                if (mem_w_last_i) begin
                    mem_w_valid_o <= 1'b0;
                    done_o        <= 1'b1;
                end else begin
                    beat_q <= 1'b1;   // beat 0 taken, move on
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            mem_w_addr_o <= line_addr_i;
            line_q       <= line_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/dcache_tag_array.sv
/*
 * tag, valid and dirty storage for 128 sets x 4 ways
 * all four ways compared at once against the request tag
 * free-running counter picks the victim way
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [dcache_pkg::INDEX_W-1:0] index_i,
    input  logic [dcache_pkg::TAG_W-1:0]   tag_i,
    input  logic                           we_i,
    input  logic [dcache_pkg::WAY_W-1:0]   way_i,
    input  logic                           dirty_i,
    output logic                           hit_o,
    output logic [dcache_pkg::WAY_W-1:0]   hit_way_o,
    output logic [dcache_pkg::WAY_W-1:0]   victim_way_o,
    output logic [dcache_pkg::TAG_W-1:0]   victim_tag_o,
    output logic                           victim_dirty_o
);
    import dcache_pkg::*;

    logic [TAG_W-1:0] tag_q   [SETS][WAYS];
    logic [WAYS-1:0]  valid_q [SETS];
    logic [WAYS-1:0]  dirty_q [SETS];
    logic [WAYS-1:0]  match;
    logic [WAY_W-1:0] cnt_q;   // pseudo-random victim

    always_ff @(posedge clk) begin
        if (we_i) tag_q[index_i][way_i] <= tag_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (we_i) begin
            valid_q[index_i][way_i] <= 1'b1;
            dirty_q[index_i][way_i] <= dirty_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) cnt_q <= '0;
        else     cnt_q <= cnt_q + 1'b1;
    end

    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            match[w] = valid_q[index_i][w] && (tag_q[index_i][w] == tag_i);
            if (match[w]) hit_way_o = WAY_W'(w);
        end
    end

    assign hit_o          = |match;
    assign victim_way_o   = cnt_q;
    assign victim_tag_o   = tag_q[index_i][cnt_q];
    assign victim_dirty_o = valid_q[index_i][cnt_q] && dirty_q[index_i][cnt_q];

    // refill only ever installs a tag that missed
    a_onehot_match: assert property (@(posedge clk) disable iff (rst) $onehot0(match))
        else $error("tag matches in more than one way");

endmodule

`default_nettype wire

//--- hdl/dcache_data_array.sv
/*
 * line storage, four ways of 128 x 16 bytes
 * synchronous read of all ways every cycle at index_i
 * byte-strobed write into one way, read returns the old line on a write edge
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array (
    input  logic                              clk,
    input  logic [dcache_pkg::INDEX_W-1:0]    index_i,
    input  logic                              we_i,
    input  logic [dcache_pkg::WAY_W-1:0]      way_i,
    input  logic [dcache_pkg::LINE_BYTES-1:0] strb_i,
    input  dcache_pkg::line_u                 wline_i,
    output dcache_pkg::line_u                 rline_o [dcache_pkg::WAYS]
);
    import dcache_pkg::*;

    line_u mem_q [WAYS][SETS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (we_i && way_i == WAY_W'(w) && strb_i[b])
                    mem_q[w][index_i].bytes[b] <= wline_i.bytes[b];
            end
            rline_o[w] <= mem_q[w][index_i];   // all ways, way picked downstream
        end
    end

    // every write from the controller carries at least one byte
    a_strb_nonzero: assert property (@(posedge clk) we_i |-> (strb_i != '0))
        else $error("data write with empty strobe");

endmodule

`default_nettype wire

//--- hdl/dcache_ctrl.sv
/*
 * cache controller FSM
 * hit:  IDLE -> LOOKUP -> RESPOND, store hit writes on the LOOKUP edge
 * miss: LOOKUP -> [EVICT] -> REFILL -> [MERGE] -> RESPOND
 * eviction always completes before the refill burst starts
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cpu_valid_i,
    input  logic                              cpu_we_i,
    output logic                              cpu_ready_o,
    input  logic                              hit_i,
    input  logic [dcache_pkg::WAY_W-1:0]      hit_way_i,
    input  logic [dcache_pkg::WAY_W-1:0]      victim_way_i,
    input  logic                              victim_dirty_i,
    input  logic                              fill_done_i,
    input  logic                              evict_done_i,
    input  dcache_pkg::line_u                 fill_line_i,
    input  dcache_pkg::line_u                 store_line_i,
    input  logic [dcache_pkg::LINE_BYTES-1:0] store_strb_i,
    output logic                              fill_start_o,
    output logic                              evict_start_o,
    output logic                              tag_we_o,
    output logic                              tag_dirty_o,
    output logic                              data_we_o,
    output logic [dcache_pkg::WAY_W-1:0]      data_way_o,
    output logic [dcache_pkg::LINE_BYTES-1:0] data_strb_o,
    output dcache_pkg::line_u                 data_line_o,
    output logic                              rdata_sel_fill_o
);
    import dcache_pkg::*;

    ctrl_state_e      state_q, state_d;
    logic [WAY_W-1:0] victim_q;   // way picked at lookup, used for the rest of the miss
    logic             filled_q;   // load data comes from the refill regs
    logic             miss;

    assign miss = (state_q == LOOKUP) && !hit_i;

    // engines start on the edge that leaves the previous state
    assign evict_start_o = miss && victim_dirty_i;
    assign fill_start_o  = (miss && !victim_dirty_i) || (state_q == EVICT && evict_done_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (cpu_valid_i) state_d = LOOKUP;
            LOOKUP: begin
                if (hit_i)               state_d = RESPOND;
                else if (victim_dirty_i) state_d = EVICT;
                else                     state_d = REFILL;
            end
            EVICT:   if (evict_done_i) state_d = REFILL;
            REFILL:  if (fill_done_i) state_d = cpu_we_i ? MERGE : RESPOND;
            MERGE:   state_d = RESPOND;
            RESPOND: state_d = IDLE;   // valid is dropped by the cpu now
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= IDLE;
            filled_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE)
                filled_q <= 1'b0;
            else if (state_q == REFILL && fill_done_i)
                filled_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (miss) victim_q <= victim_way_i;   // counter moves every cycle
    end

    // store hit, whole refilled line, then store merge on a miss
    assign data_we_o   = (state_q == LOOKUP && hit_i && cpu_we_i) ||
                         (state_q == REFILL && fill_done_i) ||
                         (state_q == MERGE);
    assign data_way_o  = (state_q == LOOKUP) ? hit_way_i : victim_q;
    assign data_strb_o = (state_q == REFILL) ? '1 : store_strb_i;
    assign data_line_o = (state_q == REFILL) ? fill_line_i : store_line_i;

    assign tag_we_o    = data_we_o;                // new tag, valid set
    assign tag_dirty_o = (state_q != REFILL);     // refill clean, stores dirty

    assign cpu_ready_o      = (state_q == RESPOND);
    assign rdata_sel_fill_o = filled_q;

    // one burst at a time, each engine finishes while the FSM waits for it
    a_evict_done_in_evict: assert property (@(posedge clk) disable iff (rst)
        evict_done_i |-> state_q == EVICT)
        else $error("eviction finished outside the evict state");

    a_fill_done_in_refill: assert property (@(posedge clk) disable iff (rst)
        fill_done_i |-> state_q == REFILL)
        else $error("refill finished outside the refill state");

endmodule

`default_nettype wire

//--- hdl/dcache_top.sv
/*
 * data cache top level
 * cpu side valid/ready access port, line read and write channels to memory
 * connects the controller, tag and data arrays, lane align and the two
 * burst engines
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cpu_valid_i,
    input  logic                          cpu_we_i,
    input  logic [dcache_pkg::ADDR_W-1:0] cpu_addr_i,
    input  dcache_pkg::size_e             cpu_size_i,
    input  logic [dcache_pkg::BEAT_W-1:0] cpu_wdata_i,
    output logic [dcache_pkg::BEAT_W-1:0] cpu_rdata_o,
    output logic                          cpu_ready_o,
    output logic                          mem_r_valid_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_r_addr_o,
    input  logic                          mem_r_ready_i,
    input  logic                          mem_r_last_i,
    input  logic [dcache_pkg::BEAT_W-1:0] mem_r_data_i,
    output logic                          mem_w_valid_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_w_addr_o,
    output logic [dcache_pkg::BEAT_W-1:0] mem_w_data_o,
    input  logic                          mem_w_ready_i,
    input  logic                          mem_w_last_i
);
    import dcache_pkg::*;

    logic                  hit, victim_dirty;
    logic [WAY_W-1:0]      hit_way, victim_way, data_way;
    logic [TAG_W-1:0]      victim_tag;
    logic                  fill_start, fill_done, evict_start, evict_done;
    logic                  tag_we, tag_dirty, data_we, rdata_sel_fill;
    logic [LINE_BYTES-1:0] data_strb, store_strb;
    line_u                 data_line, store_line, fill_line, sel_line;
    line_u                 rline [WAYS];
    logic [INDEX_W-1:0]    index;
    logic [ADDR_W-1:0]     fill_addr, evict_addr;

    assign index      = cpu_addr_i[OFFSET_W +: INDEX_W];
    assign fill_addr  = {cpu_addr_i[ADDR_W-1:OFFSET_W], OFFSET_W'(0)};  // line aligned
    assign evict_addr = {victim_tag, index, OFFSET_W'(0)};
    // refill regs hold the new line until respond, array read lags one write
    assign sel_line   = rdata_sel_fill ? fill_line : rline[hit_way];

    dcache_ctrl ctrl_i (
        .clk(clk), .rst(rst), .cpu_valid_i(cpu_valid_i), .cpu_we_i(cpu_we_i),
        .cpu_ready_o(cpu_ready_o), .hit_i(hit), .hit_way_i(hit_way),
        .victim_way_i(victim_way), .victim_dirty_i(victim_dirty),
        .fill_done_i(fill_done), .evict_done_i(evict_done), .fill_line_i(fill_line),
        .store_line_i(store_line), .store_strb_i(store_strb),
        .fill_start_o(fill_start), .evict_start_o(evict_start), .tag_we_o(tag_we),
        .tag_dirty_o(tag_dirty), .data_we_o(data_we), .data_way_o(data_way),
        .data_strb_o(data_strb), .data_line_o(data_line),
        .rdata_sel_fill_o(rdata_sel_fill)
    );

    dcache_tag_array tag_i (
        .clk(clk), .rst(rst), .index_i(index), .tag_i(cpu_addr_i[ADDR_W-1 -: TAG_W]),
        .we_i(tag_we), .way_i(data_way), .dirty_i(tag_dirty), .hit_o(hit),
        .hit_way_o(hit_way), .victim_way_o(victim_way), .victim_tag_o(victim_tag),
        .victim_dirty_o(victim_dirty)
    );

    dcache_data_array data_i (
        .clk(clk), .index_i(index), .we_i(data_we), .way_i(data_way),
        .strb_i(data_strb), .wline_i(data_line), .rline_o(rline)
    );

    dcache_lane_align align_i (
        .offset_i(cpu_addr_i[OFFSET_W-1:0]), .size_i(cpu_size_i), .wdata_i(cpu_wdata_i),
        .line_i(sel_line), .store_line_o(store_line), .store_strb_o(store_strb),
        .rdata_o(cpu_rdata_o)
    );

    dcache_refill refill_i (
        .clk(clk), .rst(rst), .start_i(fill_start), .line_addr_i(fill_addr),
        .mem_r_valid_o(mem_r_valid_o), .mem_r_addr_o(mem_r_addr_o),
        .mem_r_ready_i(mem_r_ready_i), .mem_r_last_i(mem_r_last_i),
        .mem_r_data_i(mem_r_data_i), .line_o(fill_line), .done_o(fill_done)
    );

    dcache_writeback wb_i (
        .clk(clk), .rst(rst), .start_i(evict_start), .line_addr_i(evict_addr),
        .line_i(rline[victim_way]), .mem_w_valid_o(mem_w_valid_o),
        .mem_w_addr_o(mem_w_addr_o), .mem_w_data_o(mem_w_data_o),
        .mem_w_ready_i(mem_w_ready_i), .mem_w_last_i(mem_w_last_i), .done_o(evict_done)
    );

endmodule

`default_nettype wire

//--- dv/tb_dcache.sv
/*
 * testbench for the data cache top level
 * random loads and stores over a small address pool, so lines are evicted often
 * memory slave answers both channels with random ready gaps
 * a byte map model of memory checks every load, write-back and the final readback
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int          N_ACCESS       = 2000;
    localparam int          RESET_CYCLES   = 16;
    localparam int          CYC_PER_ACCESS = 40;
    localparam int          N_DOUBLES      = 12 * 4 * 2;   // readback upper bound
    localparam int          MAX_CYCLES     = RESET_CYCLES + 8 +
                                             (N_ACCESS + N_DOUBLES) * CYC_PER_ACCESS;
    localparam logic [31:0] SEED           = 32'hea99_7cac;

    logic              clk, rst;
    logic              cpu_valid_i, cpu_we_i, cpu_ready_o;
    logic [ADDR_W-1:0] cpu_addr_i;
    size_e             cpu_size_i;
    logic [BEAT_W-1:0] cpu_wdata_i, cpu_rdata_o;
    logic              mem_r_valid_o, mem_r_ready_i, mem_r_last_i;
    logic [ADDR_W-1:0] mem_r_addr_o, mem_w_addr_o;
    logic [BEAT_W-1:0] mem_r_data_i, mem_w_data_o;
    logic              mem_w_valid_o, mem_w_ready_i, mem_w_last_i;

    logic [7:0] model       [logic [31:0]];   // memory as the cpu should see it
    logic [7:0] mem_img     [logic [31:0]];   // what the slave really holds
    bit         dirty_lines [logic [31:0]];   // stored to since last write-back
    bit         touched     [logic [31:0]];   // double words used, for readback
    int         err_load, err_wb, err_timing, err_idle;
    int         cycles;

    dcache_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still going after %0d cycles", cycles);
        $display("TEST FAILED");
        $finish;
    end

    // initial memory content, every address bit matters
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h96;
    endfunction

    function automatic logic [7:0] model_byte(input logic [31:0] a);
        if (model.exists(a)) return model[a];
        return fill_byte(a);
    endfunction

    function automatic logic [63:0] read_beat(input logic [31:0] a);
        logic [63:0] v;
        for (int b = 0; b < 8; b++) begin
            v[8*b +: 8] = mem_img.exists(a + 32'(b)) ? mem_img[a + 32'(b)]
                                                     : fill_byte(a + 32'(b));
        end
        return v;
    endfunction

    // model bytes for a load, zero-extended
    function automatic logic [63:0] expect_load(input logic [31:0] a, input int nbytes);
        logic [63:0] v;
        v = '0;
        for (int b = 0; b < nbytes; b++) v[8*b +: 8] = model_byte(a + 32'(b));
        return v;
    endfunction

    // 12 tags x 4 indexes, 48 lines on 16 ways of storage
    function automatic logic [31:0] pool_addr(input int t, input int i, input logic [3:0] off);
        return {21'(t * 787 + 165), 7'(i * 29 + 5), off};
    endfunction

    task automatic check_writeback(input logic [31:0] a, input logic [63:0] b0,
                                   input logic [63:0] b1);
        logic [127:0] got, exp;
        got = {b1, b0};
        for (int b = 0; b < 16; b++) begin
            exp[8*b +: 8] = model_byte(a + 32'(b));
            mem_img[a + 32'(b)] = got[8*b +: 8];   // slave takes it either way
        end
        assert (a[3:0] == 4'd0) else begin
            err_wb++;
            $display("write-back address %h is not line aligned", a);
        end
        assert (dirty_lines.exists(a)) else begin
            err_wb++;
            $display("write-back of line %h that has no store since its last write-back", a);
        end
        assert (got == exp) else begin
            err_wb++;
            $display("Mismatch writeback: line %h expected %h actual %h", a, exp, got);
        end
        dirty_lines.delete(a);
    endtask

    // read side of the slave, ready drawn each cycle
    initial begin : read_slave
        int beat;
        beat          = 0;
        mem_r_ready_i = 1'b0;
        mem_r_last_i  = 1'b0;
        mem_r_data_i  = '0;
        forever begin
            @(negedge clk);
            mem_r_ready_i = 1'b0;
            mem_r_last_i  = 1'b0;
            if (mem_r_valid_o !== 1'b1) begin
                beat = 0;
            end else if (beat < 2 && $urandom_range(0, 3) != 0) begin
                mem_r_data_i  = read_beat(mem_r_addr_o + 32'(8 * beat));
                mem_r_ready_i = 1'b1;
                mem_r_last_i  = (beat == 1);   // second beat
                beat++;
            end
        end
    end

    // write side, beat seen here is the one taken on the next rising edge
    initial begin : write_slave
        int                beat;
        logic [BEAT_W-1:0] beat0;
        beat          = 0;
        beat0         = '0;
        mem_w_ready_i = 1'b0;
        mem_w_last_i  = 1'b0;
        forever begin
            @(negedge clk);
            mem_w_ready_i = 1'b0;
            mem_w_last_i  = 1'b0;
            if (mem_w_valid_o !== 1'b1) begin
                beat = 0;
            end else if (beat < 2 && $urandom_range(0, 3) != 0) begin
                mem_w_ready_i = 1'b1;
                mem_w_last_i  = (beat == 1);
                if (beat == 0) beat0 = mem_w_data_o;
                else           check_writeback(mem_w_addr_o, beat0, mem_w_data_o);
                beat++;
            end
        end
    end

    // one cpu access, called on a falling edge, returns one falling edge after ready
    task automatic run_access(input string name, input logic we, input logic [31:0] addr,
                              input size_e size, input logic [63:0] wdata, input bit hit_exp);
        int          lat, nbytes;
        bit          saw_rd;
        logic [63:0] exp, got;
        nbytes      = 1 << size;
        exp         = expect_load(addr, nbytes);
        cpu_valid_i = 1'b1;
        cpu_we_i    = we;
        cpu_addr_i  = addr;
        cpu_size_i  = size;
        cpu_wdata_i = wdata;
        lat         = 0;
        saw_rd      = 1'b0;
        do begin
            @(negedge clk);
            lat++;
            if (mem_r_valid_o) saw_rd = 1'b1;
        end while (!cpu_ready_o);
        got         = cpu_rdata_o;
        cpu_valid_i = 1'b0;   // dropped in the cycle after ready
        if (we) begin
            for (int b = 0; b < nbytes; b++) model[addr + 32'(b)] = wdata[8*b +: 8];
            dirty_lines[{addr[31:4], 4'h0}] = 1'b1;
        end else begin
            assert (got == exp) else begin
                err_load++;
                $display("Mismatch %s: addr %h size %0d expected %h actual %h",
                         name, addr, nbytes, exp, got);
            end
        end
        touched[{addr[31:3], 3'b000}] = 1'b1;
        if (hit_exp) begin
            assert (lat == 2) else begin
                err_timing++;
                $display("Mismatch %s latency: addr %h expected 2 actual %0d", name, addr, lat);
            end
            assert (!saw_rd) else begin
                err_timing++;
                $display("read burst during %s access to addr %h, which should hit", name, addr);
            end
        end
        @(negedge clk);
    endtask

    initial begin : stimulus
        logic [31:0] addr, last_addr;
        logic [3:0]  off;
        logic        we, last_we;
        size_e       size;
        int unsigned pick;
        logic [31:0] rb_q [$];
        void'($urandom(SEED));
        rst         = 1'b1;
        cpu_valid_i = 1'b0;
        cpu_we_i    = 1'b0;
        cpu_addr_i  = '0;
        cpu_size_i  = SIZE_B;
        cpu_wdata_i = '0;
        err_load    = 0;
        err_wb      = 0;
        err_timing  = 0;
        err_idle    = 0;
        last_addr   = '0;
        last_we     = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        repeat (4) begin   // quiet until the first request
            @(negedge clk);
            assert (cpu_ready_o === 1'b0 && mem_r_valid_o === 1'b0 && mem_w_valid_o === 1'b0)
                else begin
                    err_idle++;
                    $display("ready or a channel valid is high after reset with no request");
                end
        end
        for (int n = 0; n < N_ACCESS; n++) begin
            pick = $urandom_range(0, 9);
            we   = 1'($urandom_range(0, 1));
            size = size_e'($urandom_range(0, 3));
            off  = 4'($urandom_range(0, 15)) & ~4'((1 << size) - 1);   // natural alignment
            if (last_we && pick < 3) begin
                addr = {last_addr[31:3], 3'b000};   // whole double around the store
                we   = 1'b0;
                run_access("merge", 1'b0, addr, SIZE_D, '0, 1'b1);
            end else if (n > 0 && pick < 6) begin
                addr = {last_addr[31:4], off};   // same line again
                run_access("rehit", we, addr, size, {$urandom, $urandom}, 1'b1);
            end else begin
                addr = pool_addr(int'($urandom_range(0, 11)), int'($urandom_range(0, 3)), off);
                run_access("random", we, addr, size, {$urandom, $urandom}, 1'b0);
            end
            last_addr = addr;
            last_we   = we;
            if ($urandom_range(0, 7) == 0) @(negedge clk);   // idle gap now and then
        end
        foreach (touched[a]) rb_q.push_back(a);
        foreach (rb_q[k]) run_access("readback", 1'b0, rb_q[k], SIZE_D, '0, 1'b0);
        $display("errors: load %0d, write-back %0d, hit timing %0d, after reset %0d",
                 err_load, err_wb, err_timing, err_idle);
        if (err_load + err_wb + err_timing + err_idle == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hdl/dcache_pkg.sv
hdl/dcache_lane_align.sv
hdl/dcache_refill.sv
hdl/dcache_writeback.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_array.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
dv/tb_dcache.sv

//--- Makefile
# build the cache and its testbench with Verilator, run, then scan the log

sim:
	verilator --binary --assert --timing -Wno-fatal --top-module tb_dcache -f files.f -o sim_dcache
	./obj_dir/sim_dcache > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	if grep -q "TEST FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
